// ==== design/rv32i_types_pkg.sv ====
/* rv32i types package.
   Shared widths and enums for the load/store unit and its APB data RAM. */
package rv32i_types_pkg;

  // data and address width of the core.
  localparam int XLEN = 32;

  // one APB write strobe per byte lane.
  localparam int STRB_W = XLEN / 8;

  // major opcodes accepted by the unit; anything else is illegal.
  typedef enum logic [6:0] {
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_t;

  // access widths follow funct3, stores use only LB, LH and LW.
  typedef enum logic [2:0] {
    LB      = 3'b000,
    LH      = 3'b001,
    LW      = 3'b010,
    LBU     = 3'b100,
    LHU     = 3'b101,
    NO_LOAD = 3'b111
  } load_t;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_LOAD  = 2'b01,
    MEM_STORE = 2'b10
  } mem_op_t;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    SETUP  = 2'b01,
    ACCESS = 2'b10,
    FINISH = 2'b11
  } lsu_state_t;

  typedef enum logic [1:0] {
    ST_OK         = 2'b00,
    ST_MISALIGNED = 2'b01,
    ST_BUS_ERROR  = 2'b10,
    ST_ILLEGAL    = 2'b11
  } lsu_status_t;

endpackage

// ==== design/apb_if.sv ====
/* APB bus between the load/store execute stage and the data RAM. */
`timescale 1ns/1ps

interface apb_if
  import rv32i_types_pkg::*;
();

  // request side, driven by the master.
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [XLEN-1:0]   paddr;
  logic [XLEN-1:0]   pwdata;
  logic [STRB_W-1:0] pstrb;

  // response side, driven by the slave.
  logic [XLEN-1:0]   prdata;
  logic              pready;
  logic              pslverr;

  modport master (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

// ==== design/lsu_decode.sv ====
/* memory instruction decoder.
   Splits an RV32I word into operation, access width and immediate offset. */
`timescale 1ns/1ps

module lsu_decode
  import rv32i_types_pkg::*;
(
  input  logic [XLEN-1:0] instr,
  output mem_op_t         mem_op,
  output load_t           width,
  output logic [XLEN-1:0] imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  always_comb begin
    mem_op = MEM_NONE;
    width  = NO_LOAD;
    imm    = '0;
    if (opcode == OP_LOAD) begin
      // loads use the I-type immediate in the top twelve bits.
      imm = {{(XLEN-12){instr[31]}}, instr[31:20]};
      // funct3 codes 3, 6 and 7 have no load behind them.
      case (funct3)
        3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin
          mem_op = MEM_LOAD;
          width  = load_t'(funct3);
        end
        default: mem_op = MEM_NONE;
      endcase
    end else if (opcode == OP_STORE) begin
      // stores split the immediate around the rs2 field.
      imm = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      // only byte, halfword and word stores exist.
      if (funct3 <= 3'b010) begin
        mem_op = MEM_STORE;
        width  = load_t'(funct3);
      end
    end
  end

endmodule

// ==== design/agu.sv ====
/* address generation unit.
   Forms the effective address, the byte lanes and the misalignment flag. */
`timescale 1ns/1ps

module agu
  import rv32i_types_pkg::*;
(
  input  logic [XLEN-1:0]   port_a,
  input  logic [XLEN-1:0]   port_b,
  input  load_t             load_type,
  output logic [STRB_W-1:0] byte_en_standard,
  output logic [XLEN-1:0]   address,
  output logic              mal_addr
);

  logic [1:0] byte_offset;

  // base plus offset, wrapping like the integer adder.
  assign address     = port_a + port_b;
  assign byte_offset = address[1:0];

  // lane enables for the access, in little endian byte order.
  always_comb begin
    case (load_type)
      LB, LBU: byte_en_standard = 4'b0001 << byte_offset;
      LH, LHU: begin
        case (byte_offset)
          2'b00:   byte_en_standard = 4'b0011;
          2'b10:   byte_en_standard = 4'b1100;
          // an odd halfword has no legal lane pair.
          default: byte_en_standard = 4'b0000;
        endcase
      end
      LW:      byte_en_standard = 4'b1111;
      default: byte_en_standard = 4'b0000;
    endcase
  end

  // halfwords must sit on even addresses, words on multiples of four.
  // bytes can never be misaligned.
  always_comb begin
    case (load_type)
      LH, LHU: mal_addr = byte_offset[0];
      LW:      mal_addr = (byte_offset != 2'b00);
      default: mal_addr = 1'b0;
    endcase
  end

endmodule

// ==== design/lsu_execute.sv ====
/* load/store execute stage.
   Holds one request and runs the APB master phases for it. */
`timescale 1ns/1ps

module lsu_execute
  import rv32i_types_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              valid,
  output logic              ready,
  input  mem_op_t           mem_op,
  input  load_t             width,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   rs1_data,
  input  logic [XLEN-1:0]   rs2_data,
  output logic [XLEN-1:0]   agu_base,
  output logic [XLEN-1:0]   agu_offset,
  output load_t             agu_width,
  input  logic [XLEN-1:0]   address,
  input  logic [STRB_W-1:0] byte_en,
  input  logic              mal_addr,
  apb_if.master             apb,
  output logic [XLEN-1:0]   read_word,
  output logic [1:0]        offset,
  output mem_op_t           req_op,
  output logic              done,
  output lsu_status_t       status
);

  lsu_state_t      state;
  lsu_status_t     status_q;
  mem_op_t         op_q;
  load_t           width_q;
  logic [XLEN-1:0] base_q;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] data_q;
  logic [XLEN-1:0] read_q;
  logic [XLEN-1:0] lane_data;
  logic            accept;

  assign ready  = (state == IDLE);
  assign accept = valid && ready;

  // while idle the agu looks at the incoming request, so the misalignment
  // check is ready on the accepting edge. later it sees the held request.
  assign agu_base   = ready ? rs1_data : base_q;
  assign agu_offset = ready ? imm : imm_q;
  assign agu_width  = ready ? width : width_q;

  // request payload is captured once, at acceptance.
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= mem_op;
      width_q <= width;
      base_q  <= rs1_data;
      imm_q   <= imm;
      data_q  <= rs2_data;
    end
    // read data is taken on the completing access cycle.
    if (state == ACCESS && apb.pready) begin
      read_q <= apb.prdata;
    end
  end

  // control FSM: illegal and misaligned requests skip the bus entirely.
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      status_q <= ST_OK;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            if (mem_op == MEM_NONE) begin
              state    <= FINISH;
              status_q <= ST_ILLEGAL;
            end else if (mal_addr) begin
              state    <= FINISH;
              status_q <= ST_MISALIGNED;
            end else begin
              state    <= SETUP;
              status_q <= ST_OK;
            end
          end
        end
        SETUP:  state <= ACCESS;
        ACCESS: begin
          // the slave may stretch this phase, so wait for pready.
          if (apb.pready) begin
            state    <= FINISH;
            status_q <= apb.pslverr ? ST_BUS_ERROR : ST_OK;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // copy the store byte or halfword to every lane, then keep only the
  // lanes that the strobes select.
  always_comb begin
    logic [XLEN-1:0] rep;
    case (width_q)
      LB:      rep = {4{data_q[7:0]}};
      LH:      rep = {2{data_q[15:0]}};
      default: rep = data_q;
    endcase
    for (int i = 0; i < STRB_W; i++) begin
      lane_data[8*i +: 8] = byte_en[i] ? rep[8*i +: 8] : 8'h00;
    end
  end

  // master signals depend only on held state, so they stay stable in access.
  assign apb.psel    = (state == SETUP) || (state == ACCESS);
  assign apb.penable = (state == ACCESS);
  assign apb.pwrite  = (op_q == MEM_STORE);
  assign apb.paddr   = {address[XLEN-1:2], 2'b00};
  assign apb.pwdata  = lane_data;
  // reads carry no strobes.
  assign apb.pstrb   = apb.pwrite ? byte_en : '0;

  assign read_word = read_q;
  assign offset    = address[1:0];
  assign req_op    = op_q;
  assign done      = (state == FINISH);
  assign status    = status_q;

endmodule

// ==== design/load_align.sv ====
/* load result stage.
   Moves the addressed byte or halfword down and extends it to full width. */
`timescale 1ns/1ps

module load_align
  import rv32i_types_pkg::*;
(
  input  logic [XLEN-1:0] read_word,
  input  logic [1:0]      offset,
  input  load_t           width,
  input  mem_op_t         mem_op,
  input  lsu_status_t     status,
  output logic [XLEN-1:0] load_data
);

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] extended;

  // the addressed lane ends up in the low bits.
  assign shifted = read_word >> {offset, 3'b000};

  always_comb begin
    case (width)
      LB:      extended = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      LH:      extended = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      LBU:     extended = {{(XLEN-8){1'b0}}, shifted[7:0]};
      LHU:     extended = {{(XLEN-16){1'b0}}, shifted[15:0]};
      LW:      extended = read_word;
      default: extended = '0;
    endcase
  end

  // only a load that finished cleanly returns data.
  assign load_data = (mem_op == MEM_LOAD && status == ST_OK) ? extended : '0;

endmodule

// ==== design/data_ram_apb.sv ====
/* APB data RAM slave.
   Word memory with byte strobes, fixed wait states and a range error. */
`timescale 1ns/1ps

module data_ram_apb
  import rv32i_types_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic clk,
  input  logic reset,
  apb_if.slave apb
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] word_idx;
  logic             in_range;
  logic             access;

  assign access   = apb.psel && apb.penable;
  assign word_idx = apb.paddr[IDX_W+1:2];
  // the whole word index is checked, not just the bits that address the array.
  assign in_range = (apb.paddr[XLEN-1:2] < MEM_WORDS);

  // count the stretched access cycles, then release the bus for one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (apb.pready) begin
      wait_cnt <= '0;
    end else if (access) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign apb.pready  = access && (wait_cnt == CNT_W'(WAIT_STATES));
  assign apb.pslverr = apb.pready && !in_range;
  assign apb.prdata  = in_range ? mem[word_idx] : '0;

  // writes land on the completing cycle; an erroring write is dropped.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (apb.pready && apb.pwrite && in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (apb.pstrb[b]) begin
          mem[word_idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== design/lsu_top.sv ====
/* load/store unit top level.
   Issue port in, result port out, with the APB data RAM built in. */
`timescale 1ns/1ps

module lsu_top
  import rv32i_types_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid,
  input  logic [XLEN-1:0] instr,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output logic            ready,
  output logic            done,
  output logic [XLEN-1:0] load_data,
  output lsu_status_t     status
);

  mem_op_t           dec_op;
  load_t             dec_width;
  logic [XLEN-1:0]   dec_imm;
  logic [XLEN-1:0]   agu_base;
  logic [XLEN-1:0]   agu_offset;
  load_t             agu_width;
  logic [XLEN-1:0]   agu_address;
  logic [STRB_W-1:0] agu_byte_en;
  logic              agu_mal;
  logic [XLEN-1:0]   read_word;
  logic [1:0]        byte_offset;
  mem_op_t           req_op;

  apb_if apb_bus ();

  lsu_decode lsu_decode_inst (
    .instr  (instr),
    .mem_op (dec_op),
    .width  (dec_width),
    .imm    (dec_imm)
  );

  lsu_execute lsu_execute_inst (
    .clk        (clk),
    .reset      (reset),
    .valid      (valid),
    .ready      (ready),
    .mem_op     (dec_op),
    .width      (dec_width),
    .imm        (dec_imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .agu_base   (agu_base),
    .agu_offset (agu_offset),
    .agu_width  (agu_width),
    .address    (agu_address),
    .byte_en    (agu_byte_en),
    .mal_addr   (agu_mal),
    .apb        (apb_bus.master),
    .read_word  (read_word),
    .offset     (byte_offset),
    .req_op     (req_op),
    .done       (done),
    .status     (status)
  );

  agu agu_inst (
    .port_a           (agu_base),
    .port_b           (agu_offset),
    .load_type        (agu_width),
    .byte_en_standard (agu_byte_en),
    .address          (agu_address),
    .mal_addr         (agu_mal)
  );

  load_align load_align_inst (
    .read_word (read_word),
    .offset    (byte_offset),
    .width     (agu_width),
    .mem_op    (req_op),
    .status    (status),
    .load_data (load_data)
  );

  data_ram_apb #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) data_ram_apb_inst (
    .clk   (clk),
    .reset (reset),
    .apb   (apb_bus.slave)
  );

endmodule

// ==== sim/tb_lsu_top.sv ====
/* testbench for the load/store unit.
   Random requests from an LFSR are checked against a byte-array memory model. */
`timescale 1ns/1ps

module tb_lsu_top
  import rv32i_types_pkg::*;
();

  localparam int TIMEOUT = 50;

  logic            clk;
  logic            reset;
  logic            valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            ready;
  logic            done;
  logic [XLEN-1:0] load_data;
  lsu_status_t     status;

  // the model memory covers the 64 words of the RAM, byte by byte.
  logic [7:0]      model_mem [256];
  logic [31:0]     lfsr;

  // a request that is placed on the issue port while another is in flight.
  logic            next_valid;
  logic [XLEN-1:0] next_instr;
  logic [XLEN-1:0] next_rs1;
  logic [XLEN-1:0] next_rs2;

  lsu_top #(
    .MEM_WORDS   (64),
    .WAIT_STATES (2)
  ) lsu_top_inst (
    .clk       (clk),
    .reset     (reset),
    .valid     (valid),
    .instr     (instr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .ready     (ready),
    .done      (done),
    .load_data (load_data),
    .status    (status)
  );

  always #20 clk = ~clk;

  // galois LFSR, one step for every bit that is drawn.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic logic [XLEN-1:0] enc_load(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, 7'b0000011};
  endfunction

  function automatic logic [XLEN-1:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input lsu_status_t exp, input lsu_status_t act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("Mismatch %s: expected latency %0d, actual %0d", name, exp, act));
    end
  endtask

  // reference behavior of one request; stores that complete update the model.
  task automatic predict(input logic [XLEN-1:0] ins, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, output lsu_status_t st,
                         output logic [XLEN-1:0] data, output int lat);
    logic [2:0]      f3;
    logic            is_load;
    logic            is_store;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] val;
    int              size;
    f3       = ins[14:12];
    is_load  = (ins[6:0] == 7'b0000011) && (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
    is_store = (ins[6:0] == 7'b0100011) && (f3 <= 3'd2);
    imm      = is_store ? {{20{ins[31]}}, ins[31:25], ins[11:7]} : {{20{ins[31]}}, ins[31:20]};
    addr     = a + imm;
    size     = 1 << f3[1:0];
    data     = '0;
    val      = '0;
    lat      = 1;
    if (!is_load && !is_store) begin
      st = ST_ILLEGAL;
    end else if ((addr & (size - 1)) != 0) begin
      st = ST_MISALIGNED;
    end else if (addr >= 256) begin
      // the RAM answers out-of-range words with an error after a full transfer.
      st  = ST_BUS_ERROR;
      lat = 5;
    end else begin
      st  = ST_OK;
      lat = 5;
      for (int i = 0; i < size; i++) begin
        if (is_store) model_mem[addr[7:0] + 8'(i)] = b[8*i +: 8];
        else val[8*i +: 8] = model_mem[addr[7:0] + 8'(i)];
      end
      if (is_load) begin
        case (f3)
          3'b000:  data = {{24{val[7]}}, val[7:0]};
          3'b001:  data = {{16{val[15]}}, val[15:0]};
          default: data = val;
        endcase
      end
    end
  endtask

  // present a request on a falling edge and hold it until it is accepted.
  task automatic send(input logic [XLEN-1:0] ins, input logic [XLEN-1:0] a,
                      input logic [XLEN-1:0] b);
    int t;
    @(negedge clk);
    instr    = ins;
    rs1_data = a;
    rs2_data = b;
    valid    = 1'b1;
    t        = 0;
    while (!ready) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) abort_run("timed out waiting for ready to rise");
    end
    @(posedge clk);
  endtask

  // count falling edges from acceptance until done, ready must stay low.
  task automatic wait_done(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (next_valid) begin
        instr    = next_instr;
        rs1_data = next_rs1;
        rs2_data = next_rs2;
      end
      valid = next_valid;
      if (ready) abort_run("ready is high while a request is in flight");
      if (cycles > TIMEOUT) abort_run("timed out waiting for done");
    end while (!done);
  endtask

  task automatic run_request(input string name, input logic [XLEN-1:0] ins,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    lsu_status_t     exp_status;
    logic [XLEN-1:0] exp_data;
    int              exp_lat;
    int              lat;
    predict(ins, a, b, exp_status, exp_data, exp_lat);
    send(ins, a, b);
    wait_done(lat);
    check_latency(name, exp_lat, lat);
    check_status(name, exp_status, status);
    check_data(name, exp_data, load_data);
  endtask

  initial begin
    logic [XLEN-1:0] base;
    logic [11:0]     imm12;
    logic [2:0]      f3;
    logic [6:0]      off;
    clk        = 1'b0;
    reset      = 1'b1;
    valid      = 1'b0;
    instr      = '0;
    rs1_data   = '0;
    rs2_data   = '0;
    next_valid = 1'b0;
    next_instr = '0;
    next_rs1   = '0;
    next_rs2   = '0;
    lfsr       = 32'd1;
    for (int i = 0; i < 256; i++) model_mem[i] = 8'h00;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // store then load every width from the same word.
    for (int k = 0; k < 8; k++) begin
      base = 32'({6'(rand_bits(6)), 2'b00});
      run_request("store word", enc_store(LW, 12'd0), base, rand_bits(32));
      run_request("store byte", enc_store(LB, 12'(rand_bits(2))), base, rand_bits(32));
      run_request("store half", enc_store(LH, {11'd0, 1'(rand_bits(1))} << 1), base,
                  rand_bits(32));
      for (int j = 0; j < 4; j++) begin
        run_request("load byte", enc_load(LB, 12'(j)), base, '0);
        run_request("load byte unsigned", enc_load(LBU, 12'(j)), base, '0);
      end
      for (int j = 0; j < 4; j += 2) begin
        run_request("load half", enc_load(LH, 12'(j)), base, '0);
        run_request("load half unsigned", enc_load(LHU, 12'(j)), base, '0);
      end
      run_request("load word", enc_load(LW, 12'd0), base, '0);
    end

    // misaligned accesses never reach the RAM.
    base = 32'd64;
    run_request("misaligned store half", enc_store(LH, 12'd1), base, rand_bits(32));
    run_request("misaligned store word", enc_store(LW, 12'd2), base, rand_bits(32));
    run_request("misaligned load half", enc_load(LH, 12'd3), base, '0);
    run_request("misaligned load half unsigned", enc_load(LHU, 12'd1), base, '0);
    run_request("misaligned load word", enc_load(LW, 12'd1), base, '0);
    run_request("after misaligned", enc_load(LW, 12'd0), base, '0);

    // out-of-range words give a bus error and leave the RAM alone.
    run_request("range store word", enc_store(LW, 12'd0), 32'd256, rand_bits(32));
    run_request("range store byte", enc_store(LB, 12'd45), 32'd256, rand_bits(32));
    run_request("range load word", enc_load(LW, 12'd0), 32'h400, '0);
    run_request("range negative offset", enc_load(LW, 12'hffc), 32'd0, '0);
    for (int w = 0; w < 64; w++) begin
      run_request("readback", enc_load(LW, 12'd0), 32'(w * 4), '0);
    end

    // non-memory opcodes and unused funct3 codes.
    run_request("alu opcode", {25'(rand_bits(25)), 7'b0110011}, rand_bits(32), rand_bits(32));
    run_request("load funct3 3", enc_load(3'd3, 12'd0), 32'd0, '0);
    run_request("load funct3 6", enc_load(3'd6, 12'd0), 32'd0, '0);
    run_request("load funct3 7", enc_load(3'd7, 12'd0), 32'd0, '0);
    run_request("store funct3 3", enc_store(3'd3, 12'd0), 32'd0, rand_bits(32));
    run_request("store funct3 4", enc_store(3'd4, 12'd0), 32'd0, rand_bits(32));

    // a second request waits on the issue port until the first one is done.
    next_instr = enc_load(LW, 12'd0);
    next_rs1   = 32'd128;
    next_rs2   = '0;
    next_valid = 1'b1;
    run_request("held first", enc_store(LW, 12'd0), 32'd128, rand_bits(32));
    next_valid = 1'b0;
    run_request("held second", next_instr, next_rs1, next_rs2);

    // random mix, mostly in range and mostly aligned.
    for (int n = 0; n < 300; n++) begin
      off   = 7'(rand_bits(7));
      imm12 = (rand_bits(4) == 0) ? {5'h1f, off} : {5'h00, off};
      base  = rand_bits(7) + ((rand_bits(3) == 0) ? 32'd200 : 32'd0);
      if (rand_bits(2) != 0) begin
        base  = base & ~32'd3;
        imm12 = imm12 & ~12'd3;
      end
      if (rand_bits(3) < 4) begin
        run_request("random load", enc_load(3'(rand_bits(3)), imm12), base, '0);
      end else if (rand_bits(2) != 0) begin
        f3 = {1'b0, 2'(rand_bits(2))};
        run_request("random store", enc_store(f3, imm12), base, rand_bits(32));
      end else begin
        run_request("random opcode", {25'(rand_bits(25)), 7'(rand_bits(7))}, base,
                    rand_bits(32));
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== lsu_top.f ====
design/rv32i_types_pkg.sv
design/apb_if.sv
design/lsu_decode.sv
design/agu.sv
design/lsu_execute.sv
design/load_align.sv
design/data_ram_apb.sv
design/lsu_top.sv
sim/tb_lsu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_lsu_top
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
